//--- spi_cmd_params.svh
`ifndef SPI_CMD_PARAMS_SVH
`define SPI_CMD_PARAMS_SVH

// the command frame holds a write flag, a 3-bit address and 8-bit data.
`define SPI_CMD_WIDTH 12
`define SPI_READ_WIDTH 8
`define SPI_CMD_WR_BIT 11

// the number of system clocks per sclk period must be even.
`define SPI_CLK_DIV 4

// status register read by the poller.
`define SPI_STATUS_ADDR 7

// clocks between two poll requests.
`define SPI_POLL_INTERVAL 200

`endif

//--- spi_cmd_pkg.sv
package spi_cmd_pkg;

  // master FSM states.
  typedef enum logic [2:0] {
    idle      = 3'd0,
    start     = 3'd1,
    shift_out = 3'd2,
    shift_in  = 3'd3,
    finish    = 3'd4
  } spi_state_e;

  // decoded from the write flag of a command.
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } spi_op_e;

  // peer that issued the transaction in flight.
  typedef enum logic {
    owner_host   = 1'b0,
    owner_poller = 1'b1
  } bus_owner_e;

endpackage

//--- spi_cmd_master.sv
`timescale 1ns/1ps
`include "spi_cmd_params.svh"

module spi_cmd_master (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`SPI_CMD_WIDTH-1:0]  cmd,
  input  logic                       cmd_vld,
  output logic                       cmd_rdy,
  output logic                       sclk,
  output logic                       cs,
  output logic                       mosi,
  input  logic                       miso,
  output logic                       read_vld,
  output logic [`SPI_READ_WIDTH-1:0] read_data
);
  import spi_cmd_pkg::*;

  localparam int DIV_W = $clog2(`SPI_CLK_DIV);
  localparam int CNT_W = $clog2(`SPI_CMD_WIDTH);
  localparam logic [DIV_W-1:0] HALF_LAST = DIV_W'(`SPI_CLK_DIV / 2 - 1);
  localparam logic [DIV_W-1:0] BIT_LAST = DIV_W'(`SPI_CLK_DIV - 1);
  localparam logic [CNT_W-1:0] OUT_LAST = CNT_W'(`SPI_CMD_WIDTH - 1);
  localparam logic [CNT_W-1:0] IN_LAST = CNT_W'(`SPI_READ_WIDTH - 1);
  // clock samples from a transfer to the rise of cs or to the read_vld pulse.
  localparam int WR_CS_LAG = (`SPI_CMD_WIDTH + 1) * `SPI_CLK_DIV - `SPI_CLK_DIV / 2 + 1;
  localparam int RD_CS_LAG =
    (`SPI_CMD_WIDTH + `SPI_READ_WIDTH + 1) * `SPI_CLK_DIV - `SPI_CLK_DIV / 2 + 1;
  localparam int RD_VLD_LAG = (`SPI_CMD_WIDTH + `SPI_READ_WIDTH + 1) * `SPI_CLK_DIV + 1;

  spi_state_e                 state;
  spi_op_e                    op;
  logic [DIV_W-1:0]           div_cnt;
  logic [CNT_W-1:0]           bit_cnt;
  logic [`SPI_CMD_WIDTH-1:0]  shift_buf;
  logic [`SPI_READ_WIDTH-1:0] rx_data;
  logic                       cmd_xfer;
  logic                       half_done;
  logic                       bit_done;

  assign cmd_xfer  = cmd_vld && cmd_rdy;
  assign half_done = (div_cnt == HALF_LAST);
  assign bit_done  = (div_cnt == BIT_LAST); // the falling sclk edge, where the next mosi bit goes out.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= idle;
      op       <= op_read;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      read_vld <= 1'b0;
    end
    else
    begin
      read_vld <= 1'b0;
      case (state)
        idle:
        begin
          div_cnt <= '0;
          if (cmd_xfer)
          begin
            state <= start;
            op    <= spi_op_e'(cmd[`SPI_CMD_WR_BIT]);
          end
        end
        start:
        begin
          div_cnt <= div_cnt + 1'b1;
          if (half_done)
          begin
            state   <= shift_out;
            div_cnt <= '0;
            bit_cnt <= '0;
          end
        end
        shift_out:
        begin
          div_cnt <= bit_done ? '0 : div_cnt + 1'b1;
          if (bit_done)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == OUT_LAST)
            begin
              bit_cnt <= '0;
              state   <= (op == op_read) ? shift_in : finish;
            end
          end
        end
        shift_in:
        begin
          div_cnt <= bit_done ? '0 : div_cnt + 1'b1;
          if (bit_done)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == IN_LAST)
            begin
              bit_cnt <= '0;
              state   <= finish;
            end
          end
        end
        finish:
        begin
          div_cnt <= div_cnt + 1'b1;
          if (half_done)
          begin
            state    <= idle;
            div_cnt  <= '0;
            read_vld <= (op == op_read); // lands on the cycle cmd_rdy returns.
          end
        end
        default:
        begin
          state <= idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_xfer)
      shift_buf <= cmd;
    else if (state == shift_out && bit_done)
      shift_buf <= {shift_buf[`SPI_CMD_WIDTH-2:0], 1'b0};
    // sampled on the edge that raises sclk.
    if (state == shift_in && half_done)
      rx_data <= {rx_data[`SPI_READ_WIDTH-2:0], miso};
  end

  assign cmd_rdy   = (state == idle);
  assign cs        = !(state inside {start, shift_out, shift_in});
  assign sclk      = (state inside {shift_out, shift_in}) && (div_cnt > HALF_LAST);
  assign mosi      = (state inside {start, shift_out}) && shift_buf[`SPI_CMD_WIDTH-1];
  assign read_data = rx_data;

  // cs stays low from the transfer until the last data bit of the frame is done.
  cs_low_for_frame: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cs) |-> ($past(cmd_xfer && cmd[`SPI_CMD_WR_BIT], WR_CS_LAG) ||
                   $past(cmd_xfer && !cmd[`SPI_CMD_WR_BIT], RD_CS_LAG)));

  // a read result appears a fixed read time after a read command was taken.
  no_read_vld_after_write: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> $past(cmd_xfer && !cmd[`SPI_CMD_WR_BIT], RD_VLD_LAG));

endmodule

//--- spi_bus_arbiter.sv
`timescale 1ns/1ps
`include "spi_cmd_params.svh"

module spi_bus_arbiter (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`SPI_CMD_WIDTH-1:0] host_cmd,
  input  logic                      host_cmd_vld,
  output logic                      host_cmd_rdy,
  output logic                      host_read_vld,
  input  logic [`SPI_CMD_WIDTH-1:0] poll_cmd,
  input  logic                      poll_cmd_vld,
  output logic                      poll_cmd_rdy,
  output logic                      poll_read_vld,
  output logic [`SPI_CMD_WIDTH-1:0] cmd,
  output logic                      cmd_vld,
  input  logic                      cmd_rdy,
  input  logic                      read_vld
);
  import spi_cmd_pkg::*;

  bus_owner_e owner;
  bus_owner_e grant;
  logic       xfer;

  // host always wins and the poller only gets the bus when the host is quiet.
  assign grant = host_cmd_vld ? owner_host : owner_poller;
  assign xfer  = cmd_vld && cmd_rdy;

  assign cmd     = (grant == owner_host) ? host_cmd : poll_cmd;
  assign cmd_vld = host_cmd_vld || poll_cmd_vld;

  assign host_cmd_rdy = cmd_rdy;
  assign poll_cmd_rdy = cmd_rdy && !host_cmd_vld; // poller keeps its request pending.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      owner <= owner_host;
    else if (xfer)
      owner <= grant;
  end

  // read results go back with no extra latency.
  assign host_read_vld = read_vld && (owner == owner_host);
  assign poll_read_vld = read_vld && (owner == owner_poller);

  // the host keeps its command steady until the master takes it.
  host_holds_request: assert property (@(posedge clk) disable iff (!rst_n)
    (host_cmd_vld && !host_cmd_rdy) |=> (host_cmd_vld && $stable(host_cmd)));

endmodule

//--- status_poller.sv
`timescale 1ns/1ps
`include "spi_cmd_params.svh"

module status_poller (
  input  logic                       clk,
  input  logic                       rst_n,
  output logic [`SPI_CMD_WIDTH-1:0]  poll_cmd,
  output logic                       poll_cmd_vld,
  input  logic                       poll_cmd_rdy,
  input  logic                       poll_read_vld,
  input  logic [`SPI_READ_WIDTH-1:0] read_data,
  output logic [`SPI_READ_WIDTH-1:0] status_value,
  output logic                       status_fresh
);
  import spi_cmd_pkg::*;

  localparam int TMR_W = $clog2(`SPI_POLL_INTERVAL);
  localparam int ADDR_W = `SPI_CMD_WIDTH - 1 - `SPI_READ_WIDTH;
  localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(`SPI_POLL_INTERVAL - 1);
  localparam logic [`SPI_CMD_WIDTH-1:0] STATUS_CMD =
    {op_read, ADDR_W'(`SPI_STATUS_ADDR), {`SPI_READ_WIDTH{1'b0}}};

  logic [TMR_W-1:0] tmr;
  logic             tmr_due;
  logic             pending;

  assign tmr_due = (tmr == TMR_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tmr     <= '0;
      pending <= 1'b0;
    end
    else
    begin
      tmr <= tmr_due ? '0 : tmr + 1'b1;
      if (tmr_due)
        pending <= 1'b1; // a new request beats the clear of the old one.
      else if (poll_cmd_vld && poll_cmd_rdy)
        pending <= 1'b0;
    end
  end

  assign poll_cmd     = STATUS_CMD;
  assign poll_cmd_vld = pending;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      status_value <= '0;
      status_fresh <= 1'b0;
    end
    else
    begin
      status_fresh <= poll_read_vld;
      if (poll_read_vld)
        status_value <= read_data;
    end
  end

endmodule

//--- spi_cmd_top.sv
`timescale 1ns/1ps
`include "spi_cmd_params.svh"

module spi_cmd_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`SPI_CMD_WIDTH-1:0]  host_cmd,
  input  logic                       host_cmd_vld,
  output logic                       host_cmd_rdy,
  output logic                       host_read_vld,
  output logic [`SPI_READ_WIDTH-1:0] host_read_data,
  output logic [`SPI_READ_WIDTH-1:0] status_value,
  output logic                       status_fresh,
  output logic                       sclk,
  output logic                       cs,
  output logic                       mosi,
  input  logic                       miso
);

  logic [`SPI_CMD_WIDTH-1:0] poll_cmd;
  logic                      poll_cmd_vld;
  logic                      poll_cmd_rdy;
  logic                      poll_read_vld;
  logic [`SPI_CMD_WIDTH-1:0] cmd;
  logic                      cmd_vld;
  logic                      cmd_rdy;
  logic                      read_vld;

  // the read byte is shared and each peer qualifies it with its own read_vld.
  status_poller u_poller (
    .clk           (clk),
    .rst_n         (rst_n),
    .poll_cmd      (poll_cmd),
    .poll_cmd_vld  (poll_cmd_vld),
    .poll_cmd_rdy  (poll_cmd_rdy),
    .poll_read_vld (poll_read_vld),
    .read_data     (host_read_data),
    .status_value  (status_value),
    .status_fresh  (status_fresh)
  );

  spi_bus_arbiter u_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .host_cmd      (host_cmd),
    .host_cmd_vld  (host_cmd_vld),
    .host_cmd_rdy  (host_cmd_rdy),
    .host_read_vld (host_read_vld),
    .poll_cmd      (poll_cmd),
    .poll_cmd_vld  (poll_cmd_vld),
    .poll_cmd_rdy  (poll_cmd_rdy),
    .poll_read_vld (poll_read_vld),
    .cmd           (cmd),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .read_vld      (read_vld)
  );

  spi_cmd_master u_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (host_read_data)
  );

endmodule

//--- tb_spi_slave.sv
`timescale 1ns/1ps
`include "spi_cmd_params.svh"

module tb_spi_slave (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       sclk,
  input  logic                       cs,
  input  logic                       mosi,
  output logic                       miso,
  input  logic                       set_en,
  input  logic [2:0]                 set_addr,
  input  logic [`SPI_READ_WIDTH-1:0] set_data,
  output logic [5:0]                 last_frame_bits,
  output logic                       frame_err
);

  localparam logic [5:0] CMD_LAST = 6'(`SPI_CMD_WIDTH - 1);
  localparam logic [5:0] CMD_BITS = 6'(`SPI_CMD_WIDTH);
  localparam logic [5:0] READ_BITS = 6'(`SPI_CMD_WIDTH + `SPI_READ_WIDTH);

  logic [`SPI_READ_WIDTH-1:0] regs [0:7];
  logic                       sclk_q;
  logic                       cs_q;
  logic [5:0]                 bit_cnt;
  logic [`SPI_CMD_WIDTH-1:0]  cmd_sr;
  logic [`SPI_CMD_WIDTH-1:0]  cmd_next;
  logic [`SPI_READ_WIDTH-1:0] tx_byte;
  logic                       is_read;
  logic                       sclk_rise;
  logic                       sclk_fall;
  logic                       cmd_done;
  logic                       frame_ok;

  // sclk is oversampled with the system clock.
  assign sclk_rise = sclk && !sclk_q && !cs;
  assign sclk_fall = !sclk && sclk_q && !cs;
  assign cmd_next  = {cmd_sr[`SPI_CMD_WIDTH-2:0], mosi};
  assign cmd_done  = sclk_rise && (bit_cnt == CMD_LAST);
  assign frame_ok  = is_read ? (bit_cnt == READ_BITS) : (bit_cnt == CMD_BITS);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk_q          <= 1'b0;
      cs_q            <= 1'b1;
      bit_cnt         <= '0;
      cmd_sr          <= '0;
      tx_byte         <= '0;
      is_read         <= 1'b0;
      miso            <= 1'b0;
      last_frame_bits <= '0;
      frame_err       <= 1'b0;
    end
    else
    begin
      sclk_q <= sclk;
      cs_q   <= cs;
      if (!cs && cs_q)
      begin
        bit_cnt <= '0;
        miso    <= 1'b0;
      end
      if (sclk_rise)
      begin
        bit_cnt <= bit_cnt + 6'd1;
        if (bit_cnt < CMD_BITS)
          cmd_sr <= cmd_next;
        if (cmd_done)
        begin
          is_read <= !cmd_next[`SPI_CMD_WR_BIT];
          tx_byte <= regs[cmd_next[`SPI_CMD_WR_BIT-1:`SPI_READ_WIDTH]];
        end
      end
      // read data goes out MSB first on each falling edge after the command.
      if (sclk_fall && is_read && bit_cnt >= CMD_BITS)
      begin
        miso    <= tx_byte[`SPI_READ_WIDTH-1];
        tx_byte <= {tx_byte[`SPI_READ_WIDTH-2:0], 1'b0};
      end
      if (cs && !cs_q)
      begin
        last_frame_bits <= bit_cnt;
        if (!frame_ok)
          frame_err <= 1'b1; // sticky until the next reset.
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (set_en)
      regs[set_addr] <= set_data;
    else if (cmd_done && cmd_next[`SPI_CMD_WR_BIT])
      regs[cmd_next[`SPI_CMD_WR_BIT-1:`SPI_READ_WIDTH]] <= cmd_next[`SPI_READ_WIDTH-1:0];
  end

endmodule

//--- tb_spi_cmd_top.sv
`timescale 1ns/1ps
`include "spi_cmd_params.svh"

module tb_spi_cmd_top;

  localparam int MAX_OPS = 64;
  localparam int WRITE_CYCLES = (`SPI_CMD_WIDTH + 1) * `SPI_CLK_DIV;
  localparam int READ_CYCLES = (`SPI_CMD_WIDTH + `SPI_READ_WIDTH + 1) * `SPI_CLK_DIV;
  localparam int RDY_TIMEOUT = 4 * READ_CYCLES;
  localparam int DONE_TIMEOUT = 2 * READ_CYCLES;
  localparam int FRESH_TIMEOUT = 5 * `SPI_POLL_INTERVAL;
  localparam logic [7:0] KIND_INIT = 8'h01;
  localparam logic [7:0] KIND_WRITE = 8'h02;
  localparam logic [7:0] KIND_READ = 8'h03;
  localparam logic [7:0] KIND_STATUS = 8'h04;
  localparam logic [7:0] KIND_IDLE = 8'h05;
  localparam logic [7:0] KIND_END = 8'h0f;

  logic                       clk;
  logic                       rst_n;
  logic [`SPI_CMD_WIDTH-1:0]  host_cmd;
  logic                       host_cmd_vld;
  logic                       host_cmd_rdy;
  logic                       host_read_vld;
  logic [`SPI_READ_WIDTH-1:0] host_read_data;
  logic [`SPI_READ_WIDTH-1:0] status_value;
  logic                       status_fresh;
  logic                       sclk;
  logic                       cs;
  logic                       mosi;
  logic                       miso;
  logic                       set_en;
  logic [2:0]                 set_addr;
  logic [`SPI_READ_WIDTH-1:0] set_data;
  logic [5:0]                 last_frame_bits;
  logic                       frame_err;
  logic [7:0]                 golden [0:4*MAX_OPS-1];
  int                         gap_limit;

  spi_cmd_top dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .host_cmd       (host_cmd),
    .host_cmd_vld   (host_cmd_vld),
    .host_cmd_rdy   (host_cmd_rdy),
    .host_read_vld  (host_read_vld),
    .host_read_data (host_read_data),
    .status_value   (status_value),
    .status_fresh   (status_fresh),
    .sclk           (sclk),
    .cs             (cs),
    .mosi           (mosi),
    .miso           (miso)
  );

  tb_spi_slave slave0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .sclk            (sclk),
    .cs              (cs),
    .mosi            (mosi),
    .miso            (miso),
    .set_en          (set_en),
    .set_addr        (set_addr),
    .set_data        (set_data),
    .last_frame_bits (last_frame_bits),
    .frame_err       (frame_err)
  );

  always
  begin
    #50 clk = ~clk;
  end

  task automatic abort_run(input string what);
    begin
      $display("%s", what);
      $display("Finished with errors");
      $fatal(1, "simulation stopped");
    end
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    begin
      if (expected != actual)
        abort_run($sformatf("error: %s expected 0x%0h actual 0x%0h", name, expected, actual));
    end
  endtask

  task automatic set_slave_reg(input logic [7:0] addr, input logic [7:0] data);
    begin
      set_addr = addr[2:0];
      set_data = data;
      set_en   = 1'b1;
      @(negedge clk);
      set_en   = 1'b0;
    end
  endtask

  task automatic issue_cmd(input logic [`SPI_CMD_WIDTH-1:0] cmd_word);
    int waited;
    begin
      waited       = 0;
      host_cmd     = cmd_word;
      host_cmd_vld = 1'b1;
      while (!host_cmd_rdy)
      begin
        if (waited >= RDY_TIMEOUT)
          abort_run($sformatf("host_cmd_rdy stayed low for %0d cycles", waited));
        waited++;
        @(negedge clk);
      end
      @(negedge clk); // the command was taken on the rising edge just passed.
      host_cmd_vld = 1'b0;
    end
  endtask

  task automatic wait_done(input logic is_read, input string name);
    int cycles;
    begin
      cycles = 0;
      while (is_read ? !host_read_vld : !host_cmd_rdy)
      begin
        if (cycles >= DONE_TIMEOUT)
          abort_run($sformatf("%s never completed within %0d cycles", name, cycles));
        cycles++;
        @(negedge clk);
      end
      check_value($sformatf("%s latency", name), is_read ? READ_CYCLES : WRITE_CYCLES, cycles);
      check_value($sformatf("%s cmd_rdy", name), 1, int'(host_cmd_rdy));
      check_value($sformatf("%s read_vld", name), int'(is_read), int'(host_read_vld));
      check_value($sformatf("%s frame bits", name),
                  is_read ? `SPI_CMD_WIDTH + `SPI_READ_WIDTH : `SPI_CMD_WIDTH,
                  int'(last_frame_bits));
      check_value($sformatf("%s framing", name), 0, int'(frame_err));
    end
  endtask

  task automatic host_op(input logic is_read, input logic [7:0] addr, input logic [7:0] data,
                         input logic [7:0] want, input int op);
    string name;
    int    gap;
    begin
      if (is_read)
        name = $sformatf("op %0d read addr %0d", op, addr);
      else
        name = $sformatf("op %0d write addr %0d", op, addr);
      issue_cmd({!is_read, addr[2:0], data});
      wait_done(is_read, name);
      if (is_read)
        check_value($sformatf("%s data", name), int'(want), int'(host_read_data));
      gap = int'($urandom_range(gap_limit, 0));
      repeat (gap) @(negedge clk);
    end
  endtask

  task automatic wait_fresh(input string name);
    int waited;
    begin
      waited = 0;
      while (!status_fresh)
      begin
        if (waited >= FRESH_TIMEOUT)
          abort_run($sformatf("%s: status_fresh never pulsed in %0d cycles", name, waited));
        waited++;
        @(negedge clk);
      end
    end
  endtask

  task automatic status_op(input logic [7:0] addr, input logic [7:0] data,
                           input logic [7:0] want, input int op);
    string name;
    begin
      name = $sformatf("op %0d status", op);
      wait_fresh(name); // a poll read has just ended, so the next one decodes after the set.
      set_slave_reg(addr, data);
      wait_fresh(name);
      check_value(name, int'(want), int'(status_value));
    end
  endtask

  task automatic run_golden();
    int         op;
    logic       finished;
    logic [7:0] kind;
    logic [7:0] addr;
    logic [7:0] data;
    logic [7:0] want;
    begin
      op       = 0;
      finished = 1'b0;
      while (!finished && op < MAX_OPS)
      begin
        kind = golden[4*op];
        addr = golden[4*op+1];
        data = golden[4*op+2];
        want = golden[4*op+3];
        case (kind)
          KIND_INIT:   set_slave_reg(addr, data);
          KIND_WRITE:  host_op(1'b0, addr, data, want, op);
          KIND_READ:   host_op(1'b1, addr, data, want, op);
          KIND_STATUS: status_op(addr, data, want, op);
          KIND_IDLE:
          begin
            repeat (int'(data)) @(negedge clk);
            gap_limit = int'(want);
          end
          KIND_END:    finished = 1'b1;
          default:     abort_run($sformatf("golden line %0d has an unknown kind", op));
        endcase
        op++;
      end
      if (!finished)
        abort_run("the golden file has no end line");
    end
  endtask

  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    host_cmd     = '0;
    host_cmd_vld = 1'b0;
    set_en       = 1'b0;
    set_addr     = '0;
    set_data     = '0;
    gap_limit    = 8;
    void'($urandom(98));
    $readmemh("spi_golden.txt", golden);
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("reset cs", 1, int'(cs));
    check_value("reset sclk", 0, int'(sclk));
    check_value("reset cmd_rdy", 1, int'(host_cmd_rdy));
    check_value("reset read_vld", 0, int'(host_read_vld));
    check_value("reset status_fresh", 0, int'(status_fresh));
    check_value("reset status_value", 0, int'(status_value));
    run_golden();
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- spi_golden.txt
// columns: kind addr data want, all hex. kinds 1 init, 2 write, 3 read, 4 status, 5 idle, f end
// idle waits data cycles, then want is the largest random gap after each host command
1 0 3c 00
1 1 a5 00
1 2 5a 00
1 3 0f 00
1 4 f0 00
1 5 81 00
1 6 7e 00
1 7 11 00
3 2 00 5a
3 5 00 81
2 3 c3 00
3 3 00 c3
2 0 96 00
2 6 01 00
3 0 00 96
3 6 00 01
4 7 42 42
5 0 40 00
2 1 e7 00
3 1 00 e7
3 4 00 f0
2 4 2d 00
3 4 00 2d
2 5 ff 00
3 5 00 ff
3 2 00 5a
2 2 00 00
3 2 00 00
5 0 10 08
4 7 b9 b9
3 6 00 01
f 0 00 00

//--- files.f
+incdir+.
spi_cmd_pkg.sv
spi_cmd_master.sv
spi_bus_arbiter.sv
status_poller.sv
spi_cmd_top.sv
tb_spi_slave.sv
tb_spi_cmd_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the SPI command testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_exe=sim_spi_cmd
log_file=sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module tb_spi_cmd_top \
  -f files.f -Mdir "$build_dir" -o "$sim_exe"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/$sim_exe" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

grep -qx "Finished with no errors" "$log_file"
if [ $? -ne 0 ]; then
  echo "pass message not found in $log_file"
  exit 1
fi
exit 0
